/* files.f */
common/htable_pkg.sv
common/db_pkg.sv
src/htable_hash.sv
htable_core/htable_rd_ctxt_fifo.sv
htable_core/htable_core.sv
src/htable_init_fsm.sv
src/htable_init_counter.sv
src/htable_mem.sv
src/htable_top.sv
test/tb_htable.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the hash table testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_htable \
    -f files.f \
    -o sim_htable

./obj_dir/sim_htable 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

/* test/tb_htable.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_htable;
    import htable_pkg::*;
    import db_pkg::*;

    localparam int SIZE                = 64;
    localparam int HASH_LATENCY        = 2;
    localparam int NUM_RD_TRANSACTIONS = 8;
    localparam int CLK_PERIOD          = 4;
    localparam int POOL_SIZE           = 16;
    localparam int RAND_CYCLES         = 300;
    // Rough length of all directed and random stimulus
    localparam int STIM_CYCLES         = 600;
    localparam int RUN_CYCLES          = STIM_CYCLES + 2 * (SIZE + 50);

    logic     clk;
    logic     rst_n;
    logic     init;
    logic     init_done;
    db_req_t  update_req;
    db_req_t  lookup_req;
    db_resp_t update_resp;
    db_resp_t lookup_resp;

    // Reference table, one word per slot
    entry_t                model_tbl [int];
    // Request strobes, one bit per cycle of age
    logic [HASH_LATENCY+1:0] upd_hist;
    logic [HASH_LATENCY+1:0] lkp_hist;
    // Expected lookup results, aged like lkp_hist
    logic [HASH_LATENCY+1:0] exp_hit;
    value_t                exp_val [HASH_LATENCY+2];
    // Expected init_done and cycles of clear left
    logic                  exp_done;
    int                    low_left;

    logic [31:0] lfsr;
    key_t        pool [POOL_SIZE];
    int          err_cnt;
    int          upd_acks;
    int          lkp_acks;

    htable_top #(
        .SIZE                (SIZE),
        .HASH_LATENCY        (HASH_LATENCY),
        .NUM_RD_TRANSACTIONS (NUM_RD_TRANSACTIONS)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .init        (init),
        .init_done   (init_done),
        .update_req  (update_req),
        .lookup_req  (lookup_req),
        .update_resp (update_resp),
        .lookup_resp (lookup_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Slot = low bits of key ^ rotr(key, 7)
    function automatic int slot_of(input key_t k);
        logic [15:0] mixed;
        mixed = k ^ ((k >> 7) | (k << 9));
        return int'(mixed) % SIZE;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // One cycle of requests, from one falling edge to the next
    task automatic send(input logic upd_on, input key_t ukey, input logic uvalid,
                        input value_t uval, input logic lkp_on, input key_t lkey);
        update_req.req   = upd_on;
        update_req.key   = ukey;
        update_req.valid = uvalid;
        update_req.value = uval;
        lookup_req.req   = lkp_on;
        lookup_req.key   = lkey;
        @(negedge clk);
        update_req = '0;
        lookup_req = '0;
    endtask

    // Until every issued request has been acked and checked
    task automatic drain();
        while (upd_hist != '0 || lkp_hist != '0) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_ready();
        while (!init_done) begin
            @(negedge clk);
        end
    endtask

    task automatic lookup_pool();
        for (int i = 0; i < POOL_SIZE; i++) begin
            send(1'b0, '0, 1'b0, '0, 1'b1, pool[i]);
        end
        drain();
    endtask

    // Two more keys sharing the slot of a
    task automatic collide_test(input key_t a);
        key_t        b;
        key_t        c;
        key_t        cand;
        int          found;
        logic [31:0] bits;
        b = a;
        c = a;
        found = 0;
        for (int i = 1; i < 65536 && found < 2; i++) begin
            cand = a ^ 16'(i);
            if (slot_of(cand) == slot_of(a)) begin
                if (found == 0) begin
                    b = cand;
                end else begin
                    c = cand;
                end
                found++;
            end
        end
        take_bits(16, bits);
        send(1'b1, a, 1'b1, bits[15:0], 1'b0, '0);
        take_bits(16, bits);
        // Later insert overwrites the slot
        send(1'b1, b, 1'b1, bits[15:0], 1'b0, '0);
        send(1'b0, '0, 1'b0, '0, 1'b1, a);
        send(1'b0, '0, 1'b0, '0, 1'b1, b);
        send(1'b0, '0, 1'b0, '0, 1'b1, c);
        drain();
    endtask

    task automatic random_traffic();
        logic [31:0] bits;
        logic        upd_on;
        logic        lkp_on;
        logic        uvalid;
        key_t        ukey;
        key_t        lkey;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            take_bits(2, bits);
            upd_on = bits[1];
            lkp_on = bits[0];
            take_bits(4, bits);
            ukey = pool[bits[3:0]];
            take_bits(4, bits);
            lkey = pool[bits[3:0]];
            // Deletes about one time in four
            take_bits(2, bits);
            uvalid = (bits[1:0] != 2'b00);
            take_bits(16, bits);
            send(upd_on, ukey, uvalid, bits[15:0], lkp_on, lkey);
        end
        drain();
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    always @(posedge clk or negedge rst_n) begin : ref_model
        int     s;
        logic   hit;
        value_t hit_val;
        if (!rst_n) begin
            model_tbl.delete();
            upd_hist <= '0;
            lkp_hist <= '0;
            exp_hit  <= '0;
            for (int i = 0; i < HASH_LATENCY + 2; i++) begin
                exp_val[i] <= '0;
            end
            low_left <= SIZE + 1;
            exp_done <= 1'b0;
        end else begin
            hit     = 1'b0;
            hit_val = '0;
            // Lookup sees the table before this cycle's update
            if (lookup_req.req) begin
                s = slot_of(lookup_req.key);
                if (model_tbl.exists(s) && model_tbl[s].valid
                        && model_tbl[s].key == lookup_req.key) begin
                    hit     = 1'b1;
                    hit_val = model_tbl[s].value;
                end
            end
            if (update_req.req) begin
                s = slot_of(update_req.key);
                model_tbl[s] = '{valid: update_req.valid, key: update_req.key,
                                 value: update_req.value};
            end
            upd_hist <= {upd_hist[HASH_LATENCY:0], update_req.req};
            lkp_hist <= {lkp_hist[HASH_LATENCY:0], lookup_req.req};
            exp_hit  <= {exp_hit[HASH_LATENCY:0], hit};
            exp_val[0] <= hit_val;
            for (int i = 1; i < HASH_LATENCY + 2; i++) begin
                exp_val[i] <= exp_val[i-1];
            end
            // Clear sweep, SIZE+1 cycles without init_done
            if (init && exp_done) begin
                model_tbl.delete();
                low_left <= SIZE;
                exp_done <= 1'b0;
            end else if (low_left != 0) begin
                low_left <= low_left - 1;
                exp_done <= 1'b0;
            end else begin
                exp_done <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && update_resp.ack) begin
            upd_acks++;
        end
        if (rst_n && lookup_resp.ack) begin
            lkp_acks++;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_reset_values: assert property (@(posedge clk) $rose(rst_n) |->
        !update_resp.ack && !lookup_resp.ack && !init_done
        && !lookup_resp.valid && !lookup_resp.error && !update_resp.error)
        else begin
            err_cnt++;
            $display("[ERROR] %0t: outputs not at reset values", $time);
        end

    a_init_done: assert property (@(posedge clk) disable iff (!rst_n)
        init_done == exp_done)
        else begin
            err_cnt++;
            $display("[ERROR] %0t: init_done is %0b, expected %0b",
                     $time, init_done, exp_done);
        end

    // Update ack HASH_LATENCY+1 cycles after the request
    a_update_ack: assert property (@(posedge clk) disable iff (!rst_n)
        update_resp.ack == upd_hist[HASH_LATENCY])
        else begin
            err_cnt++;
            $display("[ERROR] %0t: update ack is %0b, expected %0b",
                     $time, update_resp.ack, upd_hist[HASH_LATENCY]);
        end

    // Lookup ack HASH_LATENCY+2 cycles after the request
    a_lookup_ack: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_resp.ack == lkp_hist[HASH_LATENCY+1])
        else begin
            err_cnt++;
            $display("[ERROR] %0t: lookup ack is %0b, expected %0b",
                     $time, lookup_resp.ack, lkp_hist[HASH_LATENCY+1]);
        end

    a_lookup_result: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_resp.ack |-> (lookup_resp.valid == exp_hit[HASH_LATENCY+1])
        && (!exp_hit[HASH_LATENCY+1] || lookup_resp.value == exp_val[HASH_LATENCY+1]))
        else begin
            err_cnt++;
            $display("[ERROR] %0t: lookup hit %0b value %h, expected hit %0b value %h",
                     $time, lookup_resp.valid, lookup_resp.value,
                     exp_hit[HASH_LATENCY+1], exp_val[HASH_LATENCY+1]);
        end

    a_no_error: assert property (@(posedge clk) disable iff (!rst_n)
        !update_resp.error && !lookup_resp.error)
        else begin
            err_cnt++;
            $display("[ERROR] %0t: error flag set on a response", $time);
        end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0] bits;
        key_t        d;
        rst_n      = 1'b0;
        init       = 1'b0;
        update_req = '0;
        lookup_req = '0;
        err_cnt    = 0;
        upd_acks   = 0;
        lkp_acks   = 0;
        lfsr       = 32'h7637;
        for (int i = 0; i < POOL_SIZE; i++) begin
            take_bits(16, bits);
            pool[i] = bits[15:0];
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        wait_ready();

        // Empty table after reset
        lookup_pool();

        // Inserts then read back
        for (int i = 0; i < 8; i++) begin
            take_bits(16, bits);
            send(1'b1, pool[i], 1'b1, bits[15:0], 1'b0, '0);
        end
        lookup_pool();

        collide_test(pool[9]);

        // Insert, hit next cycle, delete, miss
        d = pool[12];
        take_bits(16, bits);
        send(1'b1, d, 1'b1, bits[15:0], 1'b0, '0);
        send(1'b0, '0, 1'b0, '0, 1'b1, d);
        send(1'b1, d, 1'b0, '0, 1'b0, '0);
        send(1'b0, '0, 1'b0, '0, 1'b1, d);
        drain();

        random_traffic();

        // Clear by init pulse, everything misses afterwards
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        wait_ready();
        lookup_pool();

        $display("Errors: %0d, update acks: %0d, lookup acks: %0d",
                 err_cnt, upd_acks, lkp_acks);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule : tb_htable

`default_nettype wire

/* src/htable_top.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_top #(
    parameter int SIZE                = 256,
    parameter int HASH_LATENCY        = 2,
    parameter int NUM_RD_TRANSACTIONS = 8
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    init,
    output logic                   init_done,
    input  wire db_pkg::db_req_t   update_req,
    input  wire db_pkg::db_req_t   lookup_req,
    output db_pkg::db_resp_t       update_resp,
    output db_pkg::db_resp_t       lookup_resp
);
    import htable_pkg::*;

    localparam int HASH_WID = $clog2(SIZE);

    // Hash path
    key_t                update_key;
    key_t                lookup_key;
    hash_t               update_hash;
    hash_t               lookup_hash;

    // Table access
    logic                wr_en;
    logic [HASH_WID-1:0] wr_addr;
    entry_t              wr_entry;
    logic                rd_en;
    logic [HASH_WID-1:0] rd_addr;
    logic                rd_ack;
    entry_t              rd_entry;

    // Clear control
    logic                clear_active;
    logic [HASH_WID-1:0] clear_addr;
    logic                clear_last;
    logic                tbl_init;

    htable_hash #(
        .HASH_LATENCY (HASH_LATENCY)
    ) i_hash (
        .clk         (clk),
        .rst_n       (rst_n),
        .update_key  (update_key),
        .lookup_key  (lookup_key),
        .update_hash (update_hash),
        .lookup_hash (lookup_hash)
    );

    htable_core #(
        .SIZE                (SIZE),
        .HASH_LATENCY        (HASH_LATENCY),
        .NUM_RD_TRANSACTIONS (NUM_RD_TRANSACTIONS)
    ) i_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .tbl_init    (tbl_init),
        .init_done   (init_done),
        .update_req  (update_req),
        .lookup_req  (lookup_req),
        .update_resp (update_resp),
        .lookup_resp (lookup_resp),
        .update_key  (update_key),
        .lookup_key  (lookup_key),
        .update_hash (update_hash),
        .lookup_hash (lookup_hash),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_entry    (wr_entry),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_ack      (rd_ack),
        .rd_entry    (rd_entry)
    );

    // --------------------------------------------------
    // Init control and storage
    // --------------------------------------------------
    htable_init_fsm i_init_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .init         (init),
        .clear_last   (clear_last),
        .clear_active (clear_active),
        .tbl_init     (tbl_init),
        .init_done    (init_done)
    );

    htable_init_counter #(
        .SIZE (SIZE)
    ) i_init_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_active (clear_active),
        .clear_addr   (clear_addr),
        .clear_last   (clear_last)
    );

    htable_mem #(
        .SIZE (SIZE)
    ) i_mem (
        .clk          (clk),
        .clear_active (clear_active),
        .clear_addr   (clear_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_entry     (wr_entry),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_ack       (rd_ack),
        .rd_entry     (rd_entry)
    );

endmodule : htable_top

`default_nettype wire

/* src/htable_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_mem #(
    parameter int SIZE = 256
) (
    input  wire                       clk,
    // Clear port
    input  wire                       clear_active,
    input  wire [$clog2(SIZE)-1:0]    clear_addr,
    // Core write port
    input  wire                       wr_en,
    input  wire [$clog2(SIZE)-1:0]    wr_addr,
    input  wire htable_pkg::entry_t   wr_entry,
    // Core read port
    input  wire                       rd_en,
    input  wire [$clog2(SIZE)-1:0]    rd_addr,
    output logic                      rd_ack,
    output htable_pkg::entry_t        rd_entry
);
    import htable_pkg::*;

    localparam int HASH_WID = $clog2(SIZE);

    entry_t              mem [SIZE];
    logic                we;
    logic [HASH_WID-1:0] waddr;
    entry_t              wdata;

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    // Clear owns the port, writing invalid words
    assign we    = clear_active || wr_en;
    assign waddr = clear_active ? clear_addr : wr_addr;
    assign wdata = clear_active ? '0 : wr_entry;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    // Data and ack one cycle after the request
    always_ff @(posedge clk) begin
        rd_ack <= rd_en;
        if (rd_en) begin
            rd_entry <= mem[rd_addr];
        end
    end

    // Core stays idle while a clear runs
    a_no_write_in_clear: assert property (@(posedge clk)
        clear_active |-> !wr_en)
        else $error("core write during table clear");

endmodule : htable_mem

`default_nettype wire

/* src/htable_init_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_init_counter #(
    parameter int SIZE = 256
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      clear_active,
    output logic [$clog2(SIZE)-1:0]  clear_addr,
    output logic                     clear_last
);
    localparam int HASH_WID = $clog2(SIZE);

    // Held at zero between clears, so each clear starts at slot 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_addr <= '0;
        end else if (!clear_active) begin
            clear_addr <= '0;
        end else begin
            clear_addr <= clear_addr + 1'b1;
        end
    end

    // Final slot of the sweep
    assign clear_last = clear_active && (clear_addr == HASH_WID'(SIZE - 1));

endmodule : htable_init_counter

`default_nettype wire

/* src/htable_init_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_init_fsm (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  init,
    input  wire  clear_last,
    output logic clear_active,
    output logic tbl_init,
    output logic init_done
);
    import htable_pkg::*;

    init_state_t state;
    init_state_t state_next;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            // Out of reset, start clearing
            IDLE:    state_next = CLEAR;
            CLEAR:   if (clear_last) state_next = READY;
            READY:   if (init) state_next = CLEAR;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            tbl_init  <= 1'b0;
            init_done <= 1'b0;
        end else begin
            state     <= state_next;
            // Single pulse on entry to CLEAR
            tbl_init  <= (state != CLEAR) && (state_next == CLEAR);
            // Falls right after init, rises one cycle into READY
            init_done <= (state == READY) && !init;
        end
    end

    // Counter sweeps while clearing
    assign clear_active = (state == CLEAR);

endmodule : htable_init_fsm

`default_nettype wire

/* htable_core/htable_core.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_core #(
    parameter int SIZE                = 256,
    parameter int HASH_LATENCY        = 2,
    parameter int NUM_RD_TRANSACTIONS = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    // Init control
    input  wire                       tbl_init,
    input  wire                       init_done,
    // Application ports
    input  wire db_pkg::db_req_t      update_req,
    input  wire db_pkg::db_req_t      lookup_req,
    output db_pkg::db_resp_t          update_resp,
    output db_pkg::db_resp_t          lookup_resp,
    // Hash unit
    output htable_pkg::key_t          update_key,
    output htable_pkg::key_t          lookup_key,
    input  wire htable_pkg::hash_t    update_hash,
    input  wire htable_pkg::hash_t    lookup_hash,
    // Table write request
    output logic                      wr_en,
    output logic [$clog2(SIZE)-1:0]   wr_addr,
    output htable_pkg::entry_t        wr_entry,
    // Table read request and result
    output logic                      rd_en,
    output logic [$clog2(SIZE)-1:0]   rd_addr,
    input  wire                       rd_ack,
    input  wire htable_pkg::entry_t   rd_entry
);
    import htable_pkg::*;
    import db_pkg::*;

    localparam int HASH_WID = $clog2(SIZE);

    // Requests aligned with their hash
    db_req_t upd_d;
    db_req_t lkp_d;

    // Lookup context
    key_t    ctxt_key;
    logic    ctxt_uflow;
    logic    hit;

    // Response registers
    logic    upd_ack;
    logic    lkp_ack;
    logic    lkp_valid;
    logic    lkp_error;
    value_t  lkp_value;

    // --------------------------------------------------
    // Hash unit feed
    // --------------------------------------------------
    assign update_key = update_req.key;
    assign lookup_key = lookup_req.key;

    // --------------------------------------------------
    // Match request context to hash latency
    // --------------------------------------------------
    generate
        if (HASH_LATENCY == 0) begin : g_no_delay
            assign upd_d = update_req;
            assign lkp_d = lookup_req;
        end else begin : g_delay
            // Slot 0 update, slot 1 lookup
            db_req_t pipe [2][HASH_LATENCY];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < HASH_LATENCY; s++) begin
                        pipe[0][s] <= '0;
                        pipe[1][s] <= '0;
                    end
                end else begin
                    pipe[0][0] <= update_req;
                    pipe[1][0] <= lookup_req;
                    for (int s = 1; s < HASH_LATENCY; s++) begin
                        pipe[0][s] <= pipe[0][s-1];
                        pipe[1][s] <= pipe[1][s-1];
                    end
                end
            end

            assign upd_d = pipe[0][HASH_LATENCY-1];
            assign lkp_d = pipe[1][HASH_LATENCY-1];
        end
    endgenerate

    // --------------------------------------------------
    // Table requests
    // --------------------------------------------------
    // Update writes the slot, delete writes an invalid word
    assign wr_en    = upd_d.req;
    assign wr_addr  = update_hash[HASH_WID-1:0];
    assign wr_entry = '{valid: upd_d.valid, key: upd_d.key, value: upd_d.value};

    assign rd_en    = lkp_d.req;
    assign rd_addr  = lookup_hash[HASH_WID-1:0];

    // Keys of lookups in flight, popped per read ack
    htable_rd_ctxt_fifo #(
        .DEPTH   (NUM_RD_TRANSACTIONS)
    ) i_rd_ctxt_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (tbl_init),
        .wr      (rd_en),
        .wr_data (lkp_d.key),
        .rd      (rd_ack),
        .rd_data (ctxt_key),
        .full    (),
        .empty   (),
        .uflow   (ctxt_uflow)
    );

    // --------------------------------------------------
    // Responses
    // --------------------------------------------------
    // Hit needs a valid word holding the same key
    assign hit = rd_ack && rd_entry.valid && (rd_entry.key == ctxt_key);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_ack   <= 1'b0;
            lkp_ack   <= 1'b0;
            lkp_valid <= 1'b0;
            lkp_error <= 1'b0;
        end else if (tbl_init) begin
            upd_ack   <= 1'b0;
            lkp_ack   <= 1'b0;
            lkp_valid <= 1'b0;
            lkp_error <= 1'b0;
        end else begin
            // Write lands this cycle, ack next
            upd_ack   <= wr_en;
            lkp_ack   <= rd_ack;
            lkp_valid <= hit;
            lkp_error <= ctxt_uflow;
        end
    end

    // Value zero on a miss
    always_ff @(posedge clk) begin
        lkp_value <= hit ? rd_entry.value : '0;
    end

    assign update_resp = '{ack: upd_ack, error: 1'b0, valid: 1'b0, value: '0};
    assign lookup_resp = '{ack: lkp_ack, error: lkp_error, valid: lkp_valid, value: lkp_value};

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Application waits for the table clear to finish
    a_req_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (update_req.req || lookup_req.req) |-> init_done)
        else $error("request issued while table not ready");

    // Every read ack finds a stored key
    a_no_lookup_error: assert property (@(posedge clk) disable iff (!rst_n)
        !lookup_resp.error)
        else $error("lookup context underflow");

endmodule : htable_core

`default_nettype wire

/* htable_core/htable_rd_ctxt_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_rd_ctxt_fifo #(
    parameter int DEPTH = 8
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    flush,
    input  wire                    wr,
    input  wire htable_pkg::key_t  wr_data,
    input  wire                    rd,
    output htable_pkg::key_t       rd_data,
    output logic                   full,
    output logic                   empty,
    output logic                   uflow
);
    import htable_pkg::*;

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    key_t               mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               push;
    logic               pop;

    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);
    assign uflow = rd && empty;

    // Drop illegal operations
    assign push = wr && !full;
    assign pop  = rd && !empty;

    // Head of queue
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_WID'(push) - CNT_WID'(pop);
        end
    end

    // Lookups in flight never exceed depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (wr && !flush) |-> !full)
        else $error("context FIFO overflow");

endmodule : htable_rd_ctxt_fifo

`default_nettype wire

/* src/htable_hash.sv */
`timescale 1ns/1ps
`default_nettype none

module htable_hash #(
    parameter int HASH_LATENCY = 2
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire htable_pkg::key_t  update_key,
    input  wire htable_pkg::key_t  lookup_key,
    output htable_pkg::hash_t      update_hash,
    output htable_pkg::hash_t      lookup_hash
);
    import htable_pkg::*;

    // Slot 0 is the update port, slot 1 the lookup port
    hash_t hash_in [2];

    // Key XOR key rotated right by 7
    function automatic hash_t key_hash(input key_t key);
        return key ^ {key[6:0], key[15:7]};
    endfunction

    assign hash_in[0] = key_hash(update_key);
    assign hash_in[1] = key_hash(lookup_key);

    generate
        if (HASH_LATENCY == 0) begin : g_comb
            // Purely combinational hash
            assign update_hash = hash_in[0];
            assign lookup_hash = hash_in[1];
        end else begin : g_pipe
            // One register chain per port
            hash_t stage [2][HASH_LATENCY];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < HASH_LATENCY; s++) begin
                        stage[0][s] <= '0;
                        stage[1][s] <= '0;
                    end
                end else begin
                    for (int p = 0; p < 2; p++) begin
                        stage[p][0] <= hash_in[p];
                        for (int s = 1; s < HASH_LATENCY; s++) begin
                            stage[p][s] <= stage[p][s-1];
                        end
                    end
                end
            end

            // Last stage drives the outputs
            assign update_hash = stage[0][HASH_LATENCY-1];
            assign lookup_hash = stage[1][HASH_LATENCY-1];
        end
    endgenerate

endmodule : htable_hash

`default_nettype wire

/* common/db_pkg.sv */
`default_nettype none

package db_pkg;

    // --------------------------------------------------
    // Transaction requests
    // --------------------------------------------------
    // Shared by update and lookup ports
    // Lookups ignore valid and value
    typedef struct packed {
        logic               req;
        htable_pkg::key_t   key;
        // Insert when high, delete when low
        logic               valid;
        htable_pkg::value_t value;
    } db_req_t;

    // --------------------------------------------------
    // Transaction responses
    // --------------------------------------------------
    // One ack pulse per request, in request order
    typedef struct packed {
        logic               ack;
        // Context FIFO underflow
        logic               error;
        // Lookup hit
        logic               valid;
        htable_pkg::value_t value;
    } db_resp_t;

endpackage : db_pkg

`default_nettype wire

/* common/htable_pkg.sv */
`default_nettype none

package htable_pkg;

    // --------------------------------------------------
    // Key, value and hash
    // --------------------------------------------------
    // Application key
    typedef logic [15:0] key_t;

    // Value stored with each key
    typedef logic [15:0] value_t;

    // Hash at full external width
    // Each user keeps only the low log2(SIZE) bits
    typedef logic [15:0] hash_t;

    // --------------------------------------------------
    // Table word
    // --------------------------------------------------
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } entry_t;

    // --------------------------------------------------
    // Init FSM encoding
    // --------------------------------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        CLEAR = 2'd1,
        READY = 2'd2
    } init_state_t;

endpackage : htable_pkg

`default_nettype wire
